// ==== hdl/mem_pkg.sv ====
////////////////////////////////////////////////////////////
// Widths and depth of the shared boot memory bank.
// Addresses are word addresses; there are no byte enables,
// so every write replaces a full word.
////////////////////////////////////////////////////////////

package mem_pkg;

  // Command field widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Word address into the bank
  typedef logic [ADDR_W-1:0] addr_t;

  // One memory word, also the write and response payload
  typedef logic [DATA_W-1:0] data_t;

  // Full address space is backed by storage
  localparam int MEM_WORDS = 256;

endpackage

// ==== hdl/boot_pkg.sv ====
////////////////////////////////////////////////////////////
// Boot phases, configuration table and image layout.
// The configuration region and the image region must not
// overlap, and both must fit inside the memory bank.
// Image word i is IMG_KEY ^ i.
////////////////////////////////////////////////////////////

package boot_pkg;

  // Boot order: config table, program image, then run
  typedef enum logic [1:0] {
    PHASE_CFG,
    PHASE_IMAGE,
    PHASE_RUN
  } phase_e;

  // Execution cycle count, saturates at all ones
  typedef logic [31:0] cycle_t;

  localparam mem_pkg::addr_t CFG_BASE  = 8'd0;
  localparam int             CFG_WORDS = 8;

  typedef logic [$clog2(CFG_WORDS+1)-1:0] cfg_cnt_t;
  typedef logic [$clog2(CFG_WORDS)-1:0]   cfg_idx_t;

  localparam mem_pkg::data_t CFG_TABLE [CFG_WORDS] = '{
    32'h0000_0001,
    32'h0000_0100,
    32'h8000_0000,
    32'h1234_5678,
    32'hDEAD_BEEF,
    32'h0F0F_0F0F,
    32'hCAFE_0042,
    32'h7FFF_FFFF
  };

  localparam mem_pkg::addr_t IMG_BASE  = 8'd16;
  localparam int             IMG_WORDS = 64;
  localparam mem_pkg::data_t IMG_KEY   = 32'hA5C3_0000;

  // Writes the image loader may have outstanding
  localparam int IMG_INFLIGHT = 4;

  typedef logic [$clog2(IMG_WORDS+1)-1:0] img_cnt_t;

endpackage

// ==== hdl/boot_sequencer.sv ====
////////////////////////////////////////////////////////////
// Boot phase FSM. Each loader is started exactly once per
// reset; the done inputs are treated as levels. The config
// start pulse is loaded during reset and is seen for one
// cycle once reset drops.
////////////////////////////////////////////////////////////

module boot_sequencer
  (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             cfg_done_i,
    input  logic             img_done_i,
    output logic             cfg_start_o,
    output logic             img_start_o,
    output boot_pkg::phase_e phase_o,
    output logic             boot_done_o,
    output boot_pkg::cycle_t exec_cycles_o
  );

  boot_pkg::phase_e phase_r;
  boot_pkg::cycle_t exec_cycles_r;
  logic             cfg_start_r;
  logic             img_start_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      phase_r       <= boot_pkg::PHASE_CFG;
      cfg_start_r   <= 1'b1;
      img_start_r   <= 1'b0;
      exec_cycles_r <= '0;
    end
    else
    begin
      cfg_start_r <= 1'b0;
      img_start_r <= 1'b0;
      case (phase_r)
        boot_pkg::PHASE_CFG:
        begin
          if (cfg_done_i)
          begin
            phase_r     <= boot_pkg::PHASE_IMAGE;
            img_start_r <= 1'b1;
          end
        end
        boot_pkg::PHASE_IMAGE:
        begin
          if (img_done_i)
            phase_r <= boot_pkg::PHASE_RUN;
        end
        boot_pkg::PHASE_RUN:
        begin
          // Saturating count of execution cycles
          if (exec_cycles_r != '1)
            exec_cycles_r <= exec_cycles_r + 1'b1;
        end
        default:
          phase_r <= boot_pkg::PHASE_CFG;
      endcase
    end
  end

  assign cfg_start_o   = cfg_start_r;
  assign img_start_o   = img_start_r;
  assign phase_o       = phase_r;
  assign boot_done_o   = (phase_r == boot_pkg::PHASE_RUN);
  assign exec_cycles_o = exec_cycles_r;

endmodule

// ==== hdl/cfg_loader.sv ====
////////////////////////////////////////////////////////////
// Writes CFG_TABLE to consecutive words from CFG_BASE.
// Response data is not inspected; only the count matters.
// A second start restarts the table from entry zero.
////////////////////////////////////////////////////////////

module cfg_loader
  (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           start_i,
    output logic           cmd_v_o,
    output logic           cmd_we_o,
    output mem_pkg::addr_t cmd_addr_o,
    output mem_pkg::data_t cmd_wdata_o,
    input  logic           cmd_ready_i,
    input  logic           resp_v_i,
    output logic           resp_ready_o,
    output logic           done_o
  );

  logic               busy_r;
  logic               done_r;
  boot_pkg::cfg_cnt_t issue_cnt_r;
  boot_pkg::cfg_cnt_t resp_cnt_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r      <= 1'b0;
      done_r      <= 1'b0;
      issue_cnt_r <= '0;
      resp_cnt_r  <= '0;
    end
    else if (start_i)
    begin
      busy_r      <= 1'b1;
      done_r      <= 1'b0;
      issue_cnt_r <= '0;
      resp_cnt_r  <= '0;
    end
    else
    begin
      if (cmd_v_o && cmd_ready_i)
        issue_cnt_r <= issue_cnt_r + 1'b1;
      if (resp_v_i && resp_ready_o)
      begin
        resp_cnt_r <= resp_cnt_r + 1'b1;
        // Last write acknowledged
        if (resp_cnt_r == boot_pkg::CFG_WORDS - 1)
        begin
          busy_r <= 1'b0;
          done_r <= 1'b1;
        end
      end
    end
  end

  // Payload follows the issue count, which only moves on a transfer
  assign cmd_v_o      = busy_r && (issue_cnt_r != boot_pkg::CFG_WORDS);
  assign cmd_we_o     = 1'b1;
  assign cmd_addr_o   = boot_pkg::CFG_BASE + mem_pkg::addr_t'(issue_cnt_r);
  assign cmd_wdata_o  = boot_pkg::CFG_TABLE[boot_pkg::cfg_idx_t'(issue_cnt_r)];
  assign resp_ready_o = busy_r;
  assign done_o       = done_r;

endmodule

// ==== hdl/image_loader.sv ====
////////////////////////////////////////////////////////////
// Writes the generated program image from IMG_BASE.
// Up to IMG_INFLIGHT writes may be outstanding; responses
// must come back in command order. done_o is a level.
////////////////////////////////////////////////////////////

module image_loader
  (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           start_i,
    output logic           cmd_v_o,
    output logic           cmd_we_o,
    output mem_pkg::addr_t cmd_addr_o,
    output mem_pkg::data_t cmd_wdata_o,
    input  logic           cmd_ready_i,
    input  logic           resp_v_i,
    output logic           resp_ready_o,
    output logic           done_o
  );

  logic               busy_r;
  logic               done_r;
  boot_pkg::img_cnt_t issue_cnt_r;
  boot_pkg::img_cnt_t resp_cnt_r;
  boot_pkg::img_cnt_t inflight;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r      <= 1'b0;
      done_r      <= 1'b0;
      issue_cnt_r <= '0;
      resp_cnt_r  <= '0;
    end
    else if (start_i)
    begin
      busy_r      <= 1'b1;
      done_r      <= 1'b0;
      issue_cnt_r <= '0;
      resp_cnt_r  <= '0;
    end
    else
    begin
      if (cmd_v_o && cmd_ready_i)
        issue_cnt_r <= issue_cnt_r + 1'b1;
      if (resp_v_i && resp_ready_o)
      begin
        resp_cnt_r <= resp_cnt_r + 1'b1;
        if (resp_cnt_r == boot_pkg::IMG_WORDS - 1)
        begin
          busy_r <= 1'b0;
          done_r <= 1'b1;
        end
      end
    end
  end

  // Issued but not yet acknowledged
  assign inflight = issue_cnt_r - resp_cnt_r;

  // Inflight can only shrink while valid is up, so valid holds
  assign cmd_v_o = busy_r && (issue_cnt_r != boot_pkg::IMG_WORDS)
                   && (inflight < boot_pkg::IMG_INFLIGHT);

  assign cmd_we_o     = 1'b1;
  assign cmd_addr_o   = boot_pkg::IMG_BASE + mem_pkg::addr_t'(issue_cnt_r);
  assign cmd_wdata_o  = boot_pkg::IMG_KEY ^ mem_pkg::data_t'(issue_cnt_r);
  assign resp_ready_o = busy_r;
  assign done_o       = done_r;

endmodule

// ==== hdl/mem_arbiter.sv ====
////////////////////////////////////////////////////////////
// Phase-based steering of three requesters onto one bank.
// Purely combinational; the phase may only change while the
// bank has no response pending for the current owner.
////////////////////////////////////////////////////////////

module mem_arbiter
  (
    input  boot_pkg::phase_e phase_i,
    input  logic             cfg_cmd_v_i,
    input  logic             cfg_cmd_we_i,
    input  mem_pkg::addr_t   cfg_cmd_addr_i,
    input  mem_pkg::data_t   cfg_cmd_wdata_i,
    output logic             cfg_cmd_ready_o,
    output logic             cfg_resp_v_o,
    input  logic             cfg_resp_ready_i,
    input  logic             img_cmd_v_i,
    input  logic             img_cmd_we_i,
    input  mem_pkg::addr_t   img_cmd_addr_i,
    input  mem_pkg::data_t   img_cmd_wdata_i,
    output logic             img_cmd_ready_o,
    output logic             img_resp_v_o,
    input  logic             img_resp_ready_i,
    input  logic             host_cmd_v_i,
    input  logic             host_cmd_we_i,
    input  mem_pkg::addr_t   host_cmd_addr_i,
    input  mem_pkg::data_t   host_cmd_wdata_i,
    output logic             host_cmd_ready_o,
    output logic             host_resp_v_o,
    output mem_pkg::data_t   host_resp_data_o,
    input  logic             host_resp_ready_i,
    output logic             mem_cmd_v_o,
    output logic             mem_cmd_we_o,
    output mem_pkg::addr_t   mem_cmd_addr_o,
    output mem_pkg::data_t   mem_cmd_wdata_o,
    input  logic             mem_cmd_ready_i,
    input  logic             mem_resp_v_i,
    input  mem_pkg::data_t   mem_resp_data_i,
    output logic             mem_resp_ready_o
  );

  always_comb
  begin
    mem_cmd_v_o      = 1'b0;
    mem_cmd_we_o     = 1'b0;
    mem_cmd_addr_o   = '0;
    mem_cmd_wdata_o  = '0;
    mem_resp_ready_o = 1'b0;
    cfg_cmd_ready_o  = 1'b0;
    cfg_resp_v_o     = 1'b0;
    img_cmd_ready_o  = 1'b0;
    img_resp_v_o     = 1'b0;
    host_cmd_ready_o = 1'b0;
    host_resp_v_o    = 1'b0;
    host_resp_data_o = '0;
    case (phase_i)
      boot_pkg::PHASE_CFG:
      begin
        mem_cmd_v_o      = cfg_cmd_v_i;
        mem_cmd_we_o     = cfg_cmd_we_i;
        mem_cmd_addr_o   = cfg_cmd_addr_i;
        mem_cmd_wdata_o  = cfg_cmd_wdata_i;
        cfg_cmd_ready_o  = mem_cmd_ready_i;
        cfg_resp_v_o     = mem_resp_v_i;
        mem_resp_ready_o = cfg_resp_ready_i;
      end
      boot_pkg::PHASE_IMAGE:
      begin
        mem_cmd_v_o      = img_cmd_v_i;
        mem_cmd_we_o     = img_cmd_we_i;
        mem_cmd_addr_o   = img_cmd_addr_i;
        mem_cmd_wdata_o  = img_cmd_wdata_i;
        img_cmd_ready_o  = mem_cmd_ready_i;
        img_resp_v_o     = mem_resp_v_i;
        mem_resp_ready_o = img_resp_ready_i;
      end
      boot_pkg::PHASE_RUN:
      begin
        mem_cmd_v_o      = host_cmd_v_i;
        mem_cmd_we_o     = host_cmd_we_i;
        mem_cmd_addr_o   = host_cmd_addr_i;
        mem_cmd_wdata_o  = host_cmd_wdata_i;
        host_cmd_ready_o = mem_cmd_ready_i;
        host_resp_v_o    = mem_resp_v_i;
        host_resp_data_o = mem_resp_data_i;
        mem_resp_ready_o = host_resp_ready_i;
      end
      default:
      begin
        // Unused encoding, nobody owns the bank
        mem_cmd_v_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/mem_bank.sv ====
////////////////////////////////////////////////////////////
// Single-port word memory with one registered response.
// Writes answer with the stored data, reads with the word.
// Storage is not initialised; read only written words.
////////////////////////////////////////////////////////////

module mem_bank
  (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           cmd_v_i,
    input  logic           cmd_we_i,
    input  mem_pkg::addr_t cmd_addr_i,
    input  mem_pkg::data_t cmd_wdata_i,
    output logic           cmd_ready_o,
    output logic           resp_v_o,
    output mem_pkg::data_t resp_data_o,
    input  logic           resp_ready_i
  );

  mem_pkg::data_t mem_r [mem_pkg::MEM_WORDS];
  mem_pkg::data_t resp_data_r;
  logic           resp_v_r;
  logic           cmd_fire;

  // Slot free now or drained on this edge
  assign cmd_ready_o = !resp_v_r || resp_ready_i;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      if (cmd_we_i)
      begin
        mem_r[cmd_addr_i] <= cmd_wdata_i;
        resp_data_r       <= cmd_wdata_i;
      end
      else
        resp_data_r <= mem_r[cmd_addr_i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = resp_data_r;

endmodule

// ==== hdl/boot_mem_top.sv ====
////////////////////////////////////////////////////////////
// Boot and memory path around the processor harness.
// The host port is closed until boot_done_o rises; before
// that host commands are neither accepted nor answered.
////////////////////////////////////////////////////////////

module boot_mem_top
  (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             host_cmd_v_i,
    input  logic             host_cmd_we_i,
    input  mem_pkg::addr_t   host_cmd_addr_i,
    input  mem_pkg::data_t   host_cmd_wdata_i,
    output logic             host_cmd_ready_o,
    output logic             host_resp_v_o,
    output mem_pkg::data_t   host_resp_data_o,
    input  logic             host_resp_ready_i,
    output logic             boot_done_o,
    output boot_pkg::cycle_t exec_cycles_o
  );

  boot_pkg::phase_e phase;
  logic             cfg_start;
  logic             img_start;
  logic             cfg_done;
  logic             img_done;

  logic             cfg_cmd_v;
  logic             cfg_cmd_we;
  mem_pkg::addr_t   cfg_cmd_addr;
  mem_pkg::data_t   cfg_cmd_wdata;
  logic             cfg_cmd_ready;
  logic             cfg_resp_v;
  logic             cfg_resp_ready;

  logic             img_cmd_v;
  logic             img_cmd_we;
  mem_pkg::addr_t   img_cmd_addr;
  mem_pkg::data_t   img_cmd_wdata;
  logic             img_cmd_ready;
  logic             img_resp_v;
  logic             img_resp_ready;

  logic             mem_cmd_v;
  logic             mem_cmd_we;
  mem_pkg::addr_t   mem_cmd_addr;
  mem_pkg::data_t   mem_cmd_wdata;
  logic             mem_cmd_ready;
  logic             mem_resp_v;
  mem_pkg::data_t   mem_resp_data;
  logic             mem_resp_ready;

  boot_sequencer u_boot_sequencer
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cfg_done_i    (cfg_done),
      .img_done_i    (img_done),
      .cfg_start_o   (cfg_start),
      .img_start_o   (img_start),
      .phase_o       (phase),
      .boot_done_o   (boot_done_o),
      .exec_cycles_o (exec_cycles_o)
    );

  cfg_loader u_cfg_loader
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (cfg_start),
      .cmd_v_o      (cfg_cmd_v),
      .cmd_we_o     (cfg_cmd_we),
      .cmd_addr_o   (cfg_cmd_addr),
      .cmd_wdata_o  (cfg_cmd_wdata),
      .cmd_ready_i  (cfg_cmd_ready),
      .resp_v_i     (cfg_resp_v),
      .resp_ready_o (cfg_resp_ready),
      .done_o       (cfg_done)
    );

  image_loader u_image_loader
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (img_start),
      .cmd_v_o      (img_cmd_v),
      .cmd_we_o     (img_cmd_we),
      .cmd_addr_o   (img_cmd_addr),
      .cmd_wdata_o  (img_cmd_wdata),
      .cmd_ready_i  (img_cmd_ready),
      .resp_v_i     (img_resp_v),
      .resp_ready_o (img_resp_ready),
      .done_o       (img_done)
    );

  mem_arbiter u_mem_arbiter
    (
      .phase_i           (phase),
      .cfg_cmd_v_i       (cfg_cmd_v),
      .cfg_cmd_we_i      (cfg_cmd_we),
      .cfg_cmd_addr_i    (cfg_cmd_addr),
      .cfg_cmd_wdata_i   (cfg_cmd_wdata),
      .cfg_cmd_ready_o   (cfg_cmd_ready),
      .cfg_resp_v_o      (cfg_resp_v),
      .cfg_resp_ready_i  (cfg_resp_ready),
      .img_cmd_v_i       (img_cmd_v),
      .img_cmd_we_i      (img_cmd_we),
      .img_cmd_addr_i    (img_cmd_addr),
      .img_cmd_wdata_i   (img_cmd_wdata),
      .img_cmd_ready_o   (img_cmd_ready),
      .img_resp_v_o      (img_resp_v),
      .img_resp_ready_i  (img_resp_ready),
      .host_cmd_v_i      (host_cmd_v_i),
      .host_cmd_we_i     (host_cmd_we_i),
      .host_cmd_addr_i   (host_cmd_addr_i),
      .host_cmd_wdata_i  (host_cmd_wdata_i),
      .host_cmd_ready_o  (host_cmd_ready_o),
      .host_resp_v_o     (host_resp_v_o),
      .host_resp_data_o  (host_resp_data_o),
      .host_resp_ready_i (host_resp_ready_i),
      .mem_cmd_v_o       (mem_cmd_v),
      .mem_cmd_we_o      (mem_cmd_we),
      .mem_cmd_addr_o    (mem_cmd_addr),
      .mem_cmd_wdata_o   (mem_cmd_wdata),
      .mem_cmd_ready_i   (mem_cmd_ready),
      .mem_resp_v_i      (mem_resp_v),
      .mem_resp_data_i   (mem_resp_data),
      .mem_resp_ready_o  (mem_resp_ready)
    );

  mem_bank u_mem_bank
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_v_i      (mem_cmd_v),
      .cmd_we_i     (mem_cmd_we),
      .cmd_addr_i   (mem_cmd_addr),
      .cmd_wdata_i  (mem_cmd_wdata),
      .cmd_ready_o  (mem_cmd_ready),
      .resp_v_o     (mem_resp_v),
      .resp_data_o  (mem_resp_data),
      .resp_ready_i (mem_resp_ready)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// Clock with a period of 20 time units. Reset is high from
// time zero and drops on the 4th rising edge.
////////////////////////////////////////////////////////////

module tb_clock_gen
  (
    output logic clk_o,
    output logic reset_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #10 clk_o = ~clk_o;
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (4)
      @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== dv/boot_mem_checker.sv ====
////////////////////////////////////////////////////////////
// Host port properties of boot_mem_top, bound to the top.
// The cycle counter is assumed not to saturate in a run.
// fail_cnt counts failed assertions.
////////////////////////////////////////////////////////////

module boot_mem_checker
  (
    input logic             clk_i,
    input logic             reset_i,
    input logic             host_cmd_v_i,
    input logic             host_cmd_ready_i,
    input logic             host_resp_v_i,
    input mem_pkg::data_t   host_resp_data_i,
    input logic             host_resp_ready_i,
    input logic             boot_done_i,
    input boot_pkg::cycle_t exec_cycles_i
  );

  int fail_cnt = 0;

  // Host port closed and counter idle during boot
  host_closed_in_boot: assert property (@(posedge clk_i) disable iff (reset_i)
    !boot_done_i |-> !host_cmd_ready_i && !host_resp_v_i && exec_cycles_i == '0)
  else
  begin
    $error("host port active or counter running before boot done");
    fail_cnt = fail_cnt + 1;
  end

  resp_after_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    host_cmd_v_i && host_cmd_ready_i && host_resp_ready_i |=> host_resp_v_i)
  else
  begin
    $error("no host response one cycle after command transfer");
    fail_cnt = fail_cnt + 1;
  end

  // Stalled response keeps its data
  resp_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    host_resp_v_i && !host_resp_ready_i |=> host_resp_v_i && $stable(host_resp_data_i))
  else
  begin
    $error("host response dropped or changed under back-pressure");
    fail_cnt = fail_cnt + 1;
  end

  cmd_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    host_resp_v_i && !host_resp_ready_i |-> !host_cmd_ready_i)
  else
  begin
    $error("host command ready high while response stalled");
    fail_cnt = fail_cnt + 1;
  end

  exec_step: assert property (@(posedge clk_i) disable iff (reset_i)
    boot_done_i |=> boot_done_i && exec_cycles_i == $past(exec_cycles_i) + 1)
  else
  begin
    $error("execution counter did not step by one");
    fail_cnt = fail_cnt + 1;
  end

endmodule

bind boot_mem_top boot_mem_checker u_boot_mem_checker
  (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .host_cmd_v_i      (host_cmd_v_i),
    .host_cmd_ready_i  (host_cmd_ready_o),
    .host_resp_v_i     (host_resp_v_o),
    .host_resp_data_i  (host_resp_data_o),
    .host_resp_ready_i (host_resp_ready_i),
    .boot_done_i       (boot_done_o),
    .exec_cycles_i     (exec_cycles_o)
  );

// ==== dv/boot_mem_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for boot_mem_top. Host accesses start after
// reset and complete once boot is done. One host command
// is outstanding at a time; resp_ready is random.
////////////////////////////////////////////////////////////

module boot_mem_tb;

  logic             clk;
  logic             reset;
  logic             host_cmd_v;
  logic             host_cmd_we;
  mem_pkg::addr_t   host_cmd_addr;
  mem_pkg::data_t   host_cmd_wdata;
  logic             host_cmd_ready;
  logic             host_resp_v;
  mem_pkg::data_t   host_resp_data;
  logic             host_resp_ready;
  logic             boot_done;
  boot_pkg::cycle_t exec_cycles;

  integer seed = 32'h4564;
  int     n_pairs = 16;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     timeout_cycles;
  logic   done_at_accept;

  tb_clock_gen u_tb_clock_gen
    (
      .clk_o   (clk),
      .reset_o (reset)
    );

  boot_mem_top u_boot_mem_top
    (
      .clk_i             (clk),
      .reset_i           (reset),
      .host_cmd_v_i      (host_cmd_v),
      .host_cmd_we_i     (host_cmd_we),
      .host_cmd_addr_i   (host_cmd_addr),
      .host_cmd_wdata_i  (host_cmd_wdata),
      .host_cmd_ready_o  (host_cmd_ready),
      .host_resp_v_o     (host_resp_v),
      .host_resp_data_o  (host_resp_data),
      .host_resp_ready_i (host_resp_ready),
      .boot_done_o       (boot_done),
      .exec_cycles_o     (exec_cycles)
    );

  task automatic drive_cmd(input logic we, input mem_pkg::addr_t addr,
                           input mem_pkg::data_t wdata);
    host_cmd_v     <= 1'b1;
    host_cmd_we    <= we;
    host_cmd_addr  <= addr;
    host_cmd_wdata <= wdata;
  endtask

  // Command transfer first, then the response
  task automatic complete_cmd(output mem_pkg::data_t rdata);
    @(posedge clk);
    while (!host_cmd_ready)
      @(posedge clk);
    done_at_accept = boot_done;
    host_cmd_v <= 1'b0;
    @(posedge clk);
    while (!(host_resp_v && host_resp_ready))
      @(posedge clk);
    rdata = host_resp_data;
  endtask

  task automatic host_access(input logic we, input mem_pkg::addr_t addr,
                             input mem_pkg::data_t wdata, output mem_pkg::data_t rdata);
    drive_cmd(we, addr, wdata);
    complete_cmd(rdata);
  endtask

  task automatic check_word(input string what, input mem_pkg::data_t exp,
                            input mem_pkg::data_t act);
    assert (act === exp)
    else
    begin
      $display("ERROR %0t: %s expected %h actual %h", $time, what, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s: pass", name);
    else
    begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_before);
    end
  endtask

  // Random back-pressure on host responses
  initial
  begin
    host_resp_ready = 1'b1;
    forever
    begin
      @(posedge clk);
      if (!reset)
        host_resp_ready <= ($random(seed) & 3) != 0;
    end
  end

  initial
  begin
    int               err0;
    mem_pkg::addr_t   addr;
    mem_pkg::data_t   wdata;
    mem_pkg::data_t   rdata;
    boot_pkg::cycle_t cnt0;

    host_cmd_v     = 1'b0;
    host_cmd_we    = 1'b0;
    host_cmd_addr  = '0;
    host_cmd_wdata = '0;

    @(posedge clk);
    while (reset)
      @(posedge clk);

    // Read issued during boot, served only after handover
    err0 = errors;
    host_access(1'b0, boot_pkg::CFG_BASE, '0, rdata);
    assert (done_at_accept)
    else
    begin
      $display("Host command was accepted before boot finished");
      errors++;
    end
    check_word("first cfg word", boot_pkg::CFG_TABLE[0], rdata);
    finish_test("boot_handover", err0);

    err0 = errors;
    for (int i = 0; i < boot_pkg::CFG_WORDS; i++)
    begin
      addr = mem_pkg::addr_t'(boot_pkg::CFG_BASE + i);
      host_access(1'b0, addr, '0, rdata);
      check_word("cfg word", boot_pkg::CFG_TABLE[i], rdata);
    end
    finish_test("cfg_readback", err0);

    err0 = errors;
    for (int i = 0; i < boot_pkg::IMG_WORDS; i++)
    begin
      addr = mem_pkg::addr_t'(boot_pkg::IMG_BASE + i);
      host_access(1'b0, addr, '0, rdata);
      check_word("image word", boot_pkg::IMG_KEY ^ mem_pkg::data_t'(i), rdata);
    end
    finish_test("image_readback", err0);

    err0 = errors;
    for (int k = 0; k < n_pairs; k++)
    begin
      addr  = mem_pkg::addr_t'(128 + 7 * k);
      wdata = 32'h5A5A_0000 ^ (mem_pkg::data_t'(k) << 8) ^ mem_pkg::data_t'(addr);
      host_access(1'b1, addr, wdata, rdata);
      check_word("write echo", wdata, rdata);
      host_access(1'b0, addr, '0, rdata);
      check_word("read after write", wdata, rdata);
    end
    finish_test("write_readback", err0);

    err0 = errors;
    cnt0 = exec_cycles;
    repeat (50)
      @(posedge clk);
    check_word("exec cycles", cnt0 + 32'd50, exec_cycles);
    finish_test("exec_counter", err0);

    $display("tests %0d, failed %0d, value errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, u_boot_mem_top.u_boot_mem_checker.fail_cnt);
    if (tests_failed == 0 && u_boot_mem_top.u_boot_mem_checker.fail_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Budget of 20 cycles per boot and host transfer
  initial
  begin
    timeout_cycles = 20 * (2 * (boot_pkg::CFG_WORDS + boot_pkg::IMG_WORDS) + 1
                           + 2 * n_pairs) + 2000;
    repeat (timeout_cycles)
      @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== boot_mem.f ====
hdl/mem_pkg.sv
hdl/boot_pkg.sv
hdl/boot_sequencer.sv
hdl/cfg_loader.sv
hdl/image_loader.sv
hdl/mem_arbiter.sv
hdl/mem_bank.sv
hdl/boot_mem_top.sv
dv/tb_clock_gen.sv
dv/boot_mem_checker.sv
dv/boot_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= boot_mem_tb
FILELIST  ?= boot_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
